/* all.f */
hdl/cache_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_dpath.sv
hdl/blocking_cache.sv
bench/cache_assert.sv
bench/tb_blocking_cache.sv

/* Makefile */
# Verilator build and run of the blocking cache testbench

TOP = tb_blocking_cache

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f all.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_blocking_cache.sv */
/*
 * Testbench for the blocking cache with a line memory model, directed
 * and LCG-driven requests, a reference model and a response comparator.
 */

`timescale 1ns/1ps

module tb_blocking_cache;

  localparam int          idx_shamt = 0;
  // 4 KB test window of 256 lines with 16 bytes each
  localparam logic [31:0] win_base  = 32'h0004_2000;
  localparam int          nlines    = 256;
  localparam int          nwords    = 1024;
  localparam int          max_wait  = 200;

  logic                   clk;
  logic                   rst_n;
  logic                   cachereq_val;
  cache_pkg::cache_req_t  cachereq;
  logic                   busy;
  logic                   cacheresp_val;
  cache_pkg::cache_resp_t cacheresp;
  logic                   memreq_val;
  cache_pkg::mem_req_t    memreq;
  logic                   memresp_val = 1'b0;
  cache_pkg::mem_resp_t   memresp = '0;

  logic [127:0]           mem_lines [nlines];
  logic [31:0]            ref_mem [nwords];
  cache_pkg::cache_resp_t exp_q [$];
  logic [31:0]            cycle = '0;
  logic [31:0]            lcg_state;
  logic [7:0]             opaque_cnt;
  int                     rd_delay = 0;
  logic [127:0]           rd_line;
  int                     seq_errors = 0;
  int                     cmp_errors = 0;
  int                     mem_errors = 0;
  int                     checks = 0;
  // Set when a wait runs out and stops all further requests
  logic                   timed_out = 1'b0;

  blocking_cache #(
    .idx_shamt (idx_shamt)
  ) u_blocking_cache (
    .clk           (clk),
    .rst_n         (rst_n),
    .cachereq_val  (cachereq_val),
    .cachereq      (cachereq),
    .busy          (busy),
    .cacheresp_val (cacheresp_val),
    .cacheresp     (cacheresp),
    .memreq_val    (memreq_val),
    .memreq        (memreq),
    .memresp_val   (memresp_val),
    .memresp       (memresp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 32'd1;
  end

  // ======================================================================
  // Helpers and reference model
  // ======================================================================

  // Initial memory content mixes every address bit
  function automatic logic [31:0] pattern_word(logic [31:0] addr);
    pattern_word = (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5ac3_0f96;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    lcg_next  = lcg_state;
  endfunction

  // Returns the expected response data and updates the word model
  function automatic logic [31:0] ref_access(cache_pkg::req_type_e t, logic [31:0] addr,
                                             logic [31:0] data);
    logic [31:0] old;
    old = ref_mem[addr[11:2]];
    case (t)
      cache_pkg::req_write:   ref_mem[addr[11:2]] = data;
      cache_pkg::req_amo_add: ref_mem[addr[11:2]] = old + data;
      cache_pkg::req_amo_and: ref_mem[addr[11:2]] = old & data;
      cache_pkg::req_amo_or:  ref_mem[addr[11:2]] = old | data;
      default:                ref_mem[addr[11:2]] = old;
    endcase
    ref_access = (t == cache_pkg::req_write) ? 32'h0 : old;
  endfunction

  // ======================================================================
  // Memory model
  // ======================================================================

  // Read answered 3 cycles after the request, write applied at once
  always @(posedge clk) begin
    memresp_val <= 1'b0;
    if (!rst_n) begin
      rd_delay = 0;
      for (int l = 0; l < nlines; l++) begin
        for (int w = 0; w < 4; w++) begin
          mem_lines[l][w*32 +: 32] = pattern_word(win_base + 32'(l*16 + w*4));
        end
      end
    end else begin
      if (rd_delay > 0) begin
        rd_delay = rd_delay - 1;
        if (rd_delay == 0) begin
          memresp_val  <= 1'b1;
          memresp.data <= rd_line;
        end
      end
      if (memreq_val) begin
        assert (memreq.addr[31:12] == win_base[31:12] && memreq.addr[3:0] == 4'h0) else begin
          $display("ERROR: memory request at %h lies outside the test window", memreq.addr);
          mem_errors++;
        end
        if (memreq.type_ == cache_pkg::mem_write) begin
          mem_lines[memreq.addr[11:4]] = memreq.data;
        end else begin
          rd_line  = mem_lines[memreq.addr[11:4]];
          rd_delay = 3;
        end
      end
    end
  end

  // ======================================================================
  // Response comparator
  // ======================================================================

  always @(posedge clk) begin
    cache_pkg::cache_resp_t exp_resp;
    if (rst_n && cacheresp_val) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: response at %0t with no request outstanding", $time);
        cmp_errors++;
      end else begin
        exp_resp = exp_q.pop_front();
        checks++;
        assert (cacheresp.data == exp_resp.data) else begin
          $display("CHECK FAILED t=%0t cacheresp.data exp=%h got=%h",
                   $time, exp_resp.data, cacheresp.data);
          cmp_errors++;
        end
        assert (cacheresp.opaque == exp_resp.opaque) else begin
          $display("CHECK FAILED t=%0t cacheresp.opaque exp=%h got=%h",
                   $time, exp_resp.opaque, cacheresp.opaque);
          cmp_errors++;
        end
        assert (cacheresp.type_ == exp_resp.type_) else begin
          $display("CHECK FAILED t=%0t cacheresp.type exp=%0d got=%0d",
                   $time, exp_resp.type_, cacheresp.type_);
          cmp_errors++;
        end
      end
    end
  end

  // ======================================================================
  // Request sequencing
  // ======================================================================

  task automatic finish_run();
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d responses never arrived", exp_q.size());
      seq_errors++;
    end
    $display("responses checked %0d, check errors %0d, memory errors %0d, sequence errors %0d",
             checks, cmp_errors, mem_errors, seq_errors);
    if (seq_errors + cmp_errors + mem_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (busy && n < max_wait);
    if (busy) begin
      $display("ERROR: cache stayed busy for %0d cycles", max_wait);
      seq_errors++;
      timed_out = 1'b1;
    end
  endtask

  // Issue one request, wait for its response, return cycles from acceptance
  task automatic do_request(cache_pkg::req_type_e t, logic [31:0] addr, logic [31:0] data,
                            output int lat);
    cache_pkg::cache_req_t  req;
    cache_pkg::cache_resp_t exp_resp;
    logic [31:0]            accept_cycle;
    int                     n;
    lat = 0;
    if (!timed_out) begin
      wait_idle();
    end
    if (!timed_out) begin
      req.type_       = t;
      req.opaque      = opaque_cnt;
      req.addr        = addr;
      req.data        = data;
      exp_resp.type_  = t;
      exp_resp.opaque = opaque_cnt;
      exp_resp.data   = ref_access(t, addr, data);
      exp_q.push_back(exp_resp);
      cachereq_val <= 1'b1;
      cachereq     <= req;
      @(posedge clk);
      accept_cycle = cycle;
      cachereq_val <= 1'b0;
      opaque_cnt   = opaque_cnt + 8'd1;
      n = 0;
      do begin
        @(posedge clk);
        n++;
      end while (!cacheresp_val && n < max_wait);
      if (!cacheresp_val) begin
        $display("ERROR: no response to the request at %h within %0d cycles", addr, max_wait);
        seq_errors++;
        timed_out = 1'b1;
      end else begin
        lat = int'(cycle - accept_cycle);
      end
    end
  endtask

  initial begin
    int                   lat;
    int                   sel;
    logic [31:0]          r;
    logic [31:0]          d;
    logic [31:0]          a;
    cache_pkg::req_type_e t;
    rst_n        <= 1'b0;
    cachereq_val <= 1'b0;
    cachereq     <= '0;
    lcg_state    = 32'd67413;
    opaque_cnt   = 8'd0;
    for (int i = 0; i < nwords; i++) begin
      ref_mem[i] = pattern_word(win_base + 32'(i*4));
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!busy) else begin
      $display("CHECK FAILED t=%0t busy exp=0 got=%b", $time, busy);
      seq_errors++;
    end

    // Cold miss, then a hit of the same word
    a = win_base + 32'h048;
    do_request(cache_pkg::req_read, a, 32'h0, lat);
    do_request(cache_pkg::req_read, a, 32'h0, lat);
    assert (timed_out || lat == 4) else begin
      $display("CHECK FAILED t=%0t hit latency exp=4 got=%0d", $time, lat);
      seq_errors++;
    end

    // Every word of one line
    for (int w = 0; w < 4; w++) begin
      do_request(cache_pkg::req_write, win_base + 32'h100 + 32'(w*4),
                 32'h1000_0000 + 32'(w*32'h111), lat);
    end
    for (int w = 0; w < 4; w++) begin
      do_request(cache_pkg::req_read, win_base + 32'h100 + 32'(w*4), 32'h0, lat);
    end

    // AMOs, then a read of the combined word
    a = win_base + 32'h204;
    do_request(cache_pkg::req_amo_add, a, 32'h0000_1234, lat);
    do_request(cache_pkg::req_amo_and, a, 32'hff0f_f0ff, lat);
    do_request(cache_pkg::req_amo_or,  a, 32'h0a00_0005, lat);
    do_request(cache_pkg::req_read,    a, 32'h0, lat);

    // Three lines in one set force LRU eviction and write-back
    for (int k = 0; k < 3; k++) begin
      a = win_base + 32'h300 + 32'(k * (16 << (idx_shamt + 3))) + 32'h4;
      do_request(cache_pkg::req_write, a, 32'hc0de_0000 + 32'(k), lat);
    end
    for (int k = 0; k < 6; k++) begin
      a = win_base + 32'h300 + 32'((k % 3) * (16 << (idx_shamt + 3))) + 32'h4;
      do_request(cache_pkg::req_read, a, 32'h0, lat);
    end

    // Random mix over the window
    for (int i = 0; i < 400; i++) begin
      r   = lcg_next();
      d   = lcg_next();
      a   = win_base + {20'h0, r[31:22], 2'b00};
      sel = int'(r[21:14]) % 5;
      case (sel)
        0:       t = cache_pkg::req_read;
        1:       t = cache_pkg::req_write;
        2:       t = cache_pkg::req_amo_add;
        3:       t = cache_pkg::req_amo_and;
        default: t = cache_pkg::req_amo_or;
      endcase
      do_request(t, a, d, lat);
      assert (timed_out || lat >= 4) else begin
        $display("CHECK FAILED t=%0t response latency exp>=4 got=%0d", $time, lat);
        seq_errors++;
      end
    end

    repeat (2) @(posedge clk);
    finish_run();
  end

endmodule

/* bench/cache_assert.sv */
/*
 * Protocol assertions for the blocking cache.
 * Bound into every blocking_cache instance by the bind at the end.
 */

`timescale 1ns/1ps

module cache_assert (
  input logic clk,
  input logic rst_n,
  input logic cachereq_val,
  input logic busy,
  input logic cacheresp_val,
  input logic memreq_val
);

  // Set by an accepted request, cleared by its response
  logic pending;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (cachereq_val) begin
      pending <= 1'b1;
    end else if (cacheresp_val) begin
      pending <= 1'b0;
    end
  end

  // Response strobe is a single-cycle pulse
  resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    cacheresp_val |=> !cacheresp_val)
    else $error("cacheresp_val held high for more than one cycle");

  // Outputs stay quiet through reset
  quiet_in_reset: assert property (@(posedge clk)
    (!rst_n && $past(!rst_n)) |-> (!memreq_val && !cacheresp_val))
    else $error("memreq_val or cacheresp_val high during reset");

  no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    cachereq_val |-> !busy)
    else $error("cachereq_val strobed while the cache is busy");

  no_orphan_resp: assert property (@(posedge clk) disable iff (!rst_n)
    cacheresp_val |-> pending)
    else $error("cacheresp_val without an outstanding request");

endmodule

bind blocking_cache cache_assert u_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .cachereq_val  (cachereq_val),
  .busy          (busy),
  .cacheresp_val (cacheresp_val),
  .memreq_val    (memreq_val)
);

/* hdl/blocking_cache.sv */
/*
 * Top level of the blocking cache. Connects control unit and datapath.
 */

`timescale 1ns/1ps

module blocking_cache #(
  parameter int idx_shamt = 0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // Processor side
  input  logic                    cachereq_val,
  input  cache_pkg::cache_req_t   cachereq,
  output logic                    busy,
  output logic                    cacheresp_val,
  output cache_pkg::cache_resp_t  cacheresp,
  // Memory side
  output logic                    memreq_val,
  output cache_pkg::mem_req_t     memreq,
  input  logic                    memresp_val,
  input  cache_pkg::mem_resp_t    memresp
);

  cache_pkg::ctrl_t                       ctrl;
  cache_pkg::req_type_e                   req_type;
  logic [cache_pkg::idx_nbits-1:0]        set_idx;
  logic [cache_pkg::nways-1:0]            tag_match;

  cache_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cachereq_val  (cachereq_val),
    .memresp_val   (memresp_val),
    .req_type      (req_type),
    .set_idx       (set_idx),
    .tag_match     (tag_match),
    .ctrl          (ctrl),
    .busy          (busy),
    .cacheresp_val (cacheresp_val),
    .memreq_val    (memreq_val)
  );

  cache_dpath #(
    .idx_shamt (idx_shamt)
  ) u_dpath (
    .clk       (clk),
    .rst_n     (rst_n),
    .cachereq  (cachereq),
    .memresp   (memresp),
    .ctrl      (ctrl),
    .cacheresp (cacheresp),
    .memreq    (memreq),
    .req_type  (req_type),
    .set_idx   (set_idx),
    .tag_match (tag_match)
  );

endmodule

/* hdl/cache_dpath.sv */
/*
 * Cache datapath with request and refill registers, tag and data arrays,
 * tag compare, AMO unit and message packing. Steered by cache_ctrl.
 */

`timescale 1ns/1ps

module cache_dpath #(
  parameter int idx_shamt = 0
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  cache_pkg::cache_req_t                 cachereq,
  input  cache_pkg::mem_resp_t                  memresp,
  input  cache_pkg::ctrl_t                      ctrl,
  output cache_pkg::cache_resp_t                cacheresp,
  output cache_pkg::mem_req_t                   memreq,
  output cache_pkg::req_type_e                  req_type,
  output logic [cache_pkg::idx_nbits-1:0]       set_idx,
  output logic [cache_pkg::nways-1:0]           tag_match
);

  localparam int line_bytes = cache_pkg::line_nbits / 8;

  // ======================================================================
  // Request and refill registers
  // ======================================================================

  cache_pkg::req_type_e                   req_type_q;
  logic [cache_pkg::opaque_nbits-1:0]     opaque_q;
  logic [cache_pkg::addr_nbits-1:0]       addr_q;
  logic [cache_pkg::data_nbits-1:0]       data_q;
  logic [cache_pkg::line_nbits-1:0]       refill_q;
  logic [cache_pkg::line_nbits-1:0]       read_line_q;
  logic [cache_pkg::tag_nbits-1:0]        victim_tag_q;

  // Request type register read by the control unit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_type_q <= cache_pkg::req_read;
    end else if (ctrl.cachereq_en) begin
      req_type_q <= cachereq.type_;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.cachereq_en) begin
      opaque_q <= cachereq.opaque;
      addr_q   <= cachereq.addr;
      data_q   <= cachereq.data;
    end
    if (ctrl.memresp_en) begin
      refill_q <= memresp.data;
    end
  end

  assign req_type = req_type_q;

  // Address fields
  logic [cache_pkg::tag_nbits-1:0]                req_tag;
  logic [$clog2(cache_pkg::words_per_line)-1:0]   word_off;
  logic [cache_pkg::idx_nbits:0]                  line_idx;

  assign req_tag  = addr_q[cache_pkg::addr_nbits-1:cache_pkg::off_nbits];
  // Set index sits idx_shamt bits above the line offset
  assign set_idx  = addr_q[cache_pkg::off_nbits+idx_shamt +: cache_pkg::idx_nbits];
  assign word_off = addr_q[cache_pkg::off_nbits-1:2];
  // Lines of one set sit next to each other
  assign line_idx = {set_idx, ctrl.way_sel};

  // ======================================================================
  // Tag and data arrays, read combinationally
  // ======================================================================

  logic [cache_pkg::tag_nbits-1:0]  tag_array [cache_pkg::nways][cache_pkg::nsets];
  logic [cache_pkg::line_nbits-1:0] data_array [cache_pkg::nways*cache_pkg::nsets];
  logic [cache_pkg::tag_nbits-1:0]  tag_rd [cache_pkg::nways];
  logic [cache_pkg::line_nbits-1:0] line_rd;

  always_comb begin
    for (int w = 0; w < cache_pkg::nways; w++) begin
      tag_rd[w]    = tag_array[w][set_idx];
      tag_match[w] = (tag_rd[w] == req_tag);
    end
  end

  assign line_rd = data_array[line_idx];

  // Tag written only on refill and always from the request tag
  always_ff @(posedge clk) begin
    for (int w = 0; w < cache_pkg::nways; w++) begin
      if (ctrl.tag_wen[w]) begin
        tag_array[w][set_idx] <= req_tag;
      end
    end
  end

  // Latched line and victim tag
  always_ff @(posedge clk) begin
    if (ctrl.read_data_en) begin
      read_line_q <= line_rd;
    end
    if (ctrl.read_tag_en) begin
      victim_tag_q <= tag_rd[ctrl.way_sel];
    end
  end

  // ======================================================================
  // Write path
  // ======================================================================

  logic [cache_pkg::data_nbits-1:0] old_word;
  logic [cache_pkg::data_nbits-1:0] write_word;
  logic [cache_pkg::line_nbits-1:0] line_wdata;
  logic [line_bytes-1:0]            byte_en;

  assign old_word = read_line_q[word_off*cache_pkg::data_nbits +: cache_pkg::data_nbits];

  // AMO unit combines the old word with the request data
  always_comb begin
    case (req_type_q)
      cache_pkg::req_amo_add: write_word = data_q + old_word;
      cache_pkg::req_amo_and: write_word = data_q & old_word;
      cache_pkg::req_amo_or:  write_word = data_q | old_word;
      default:                write_word = data_q;
    endcase
  end

  // Refill mux picks the whole memory line or the word replicated across the line
  assign line_wdata = ctrl.is_refill ? refill_q
                                     : {cache_pkg::words_per_line{write_word}};

  // Four bytes of the addressed word, or the whole line on refill
  assign byte_en = ctrl.word_en ? (line_bytes'(4'hf) << {word_off, 2'b00})
                                : {line_bytes{1'b1}};

  always_ff @(posedge clk) begin
    for (int b = 0; b < line_bytes; b++) begin
      if (ctrl.data_wen && byte_en[b]) begin
        data_array[line_idx][b*8 +: 8] <= line_wdata[b*8 +: 8];
      end
    end
  end

  // ======================================================================
  // Message packing
  // ======================================================================

  always_comb begin
    cacheresp.type_  = req_type_q;
    cacheresp.opaque = opaque_q;
    // Writes return zero, reads and AMOs the old word
    cacheresp.data   = (req_type_q == cache_pkg::req_write) ? '0 : old_word;
  end

  // Evict uses the latched victim tag, refill the request tag
  always_comb begin
    memreq.type_ = ctrl.memreq_type;
    memreq.addr  = (ctrl.memreq_type == cache_pkg::mem_write)
                   ? {victim_tag_q, {cache_pkg::off_nbits{1'b0}}}
                   : {req_tag, {cache_pkg::off_nbits{1'b0}}};
    memreq.data  = read_line_q;
  end

endmodule

/* hdl/cache_ctrl.sv */
/*
 * Cache control unit. The FSM sequences hit, evict and refill, keeps
 * the valid, dirty and LRU state, and drives every datapath enable.
 */

`timescale 1ns/1ps

module cache_ctrl (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cachereq_val,
  input  logic                              memresp_val,
  input  cache_pkg::req_type_e              req_type,
  input  logic [cache_pkg::idx_nbits-1:0]   set_idx,
  input  logic [cache_pkg::nways-1:0]       tag_match,
  output cache_pkg::ctrl_t                  ctrl,
  output logic                              busy,
  output logic                              cacheresp_val,
  output logic                              memreq_val
);

  cache_pkg::cache_state_e state;
  cache_pkg::cache_state_e state_next;

  // One valid and one dirty bit per way per set
  // The LRU bit of a set names its older way
  logic [cache_pkg::nsets-1:0][cache_pkg::nways-1:0] valid_bits;
  logic [cache_pkg::nsets-1:0][cache_pkg::nways-1:0] dirty_bits;
  logic [cache_pkg::nsets-1:0]                       lru_bits;

  // Way chosen in tag check and held to the end of the access
  logic way_q;

  // ======================================================================
  // Hit and victim selection
  // ======================================================================

  logic [cache_pkg::nways-1:0] hit_vec;
  logic                        hit;
  logic                        hit_way;
  logic                        victim_way;
  logic                        victim_dirty;
  logic                        is_read;

  assign hit_vec = tag_match & valid_bits[set_idx];
  assign hit     = |hit_vec;
  assign hit_way = hit_vec[1];

  // Invalid way first, then the LRU way
  always_comb begin
    if (!valid_bits[set_idx][0]) begin
      victim_way = 1'b0;
    end else if (!valid_bits[set_idx][1]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_bits[set_idx];
    end
  end

  assign victim_dirty = valid_bits[set_idx][victim_way] & dirty_bits[set_idx][victim_way];
  assign is_read      = (req_type == cache_pkg::req_read);

  // ======================================================================
  // FSM next state and datapath controls
  // ======================================================================

  always_comb begin
    ctrl             = '0;
    ctrl.way_sel     = way_q;
    ctrl.memreq_type = cache_pkg::mem_read;
    state_next       = state;
    case (state)
      cache_pkg::st_idle: begin
        ctrl.cachereq_en = cachereq_val;
        if (cachereq_val) begin
          state_next = cache_pkg::st_tag_check;
        end
      end
      cache_pkg::st_tag_check: begin
        if (hit) begin
          state_next = cache_pkg::st_data_read;
        end else if (victim_dirty) begin
          state_next = cache_pkg::st_evict_read;
        end else begin
          state_next = cache_pkg::st_refill_req;
        end
      end
      cache_pkg::st_evict_read: begin
        // Latch the dirty line and its tag for write-back
        ctrl.read_data_en = 1'b1;
        ctrl.read_tag_en  = 1'b1;
        state_next        = cache_pkg::st_evict_req;
      end
      cache_pkg::st_evict_req: begin
        ctrl.memreq_type = cache_pkg::mem_write;
        state_next       = cache_pkg::st_refill_req;
      end
      cache_pkg::st_refill_req: begin
        state_next = cache_pkg::st_refill_wait;
      end
      cache_pkg::st_refill_wait: begin
        ctrl.memresp_en = memresp_val;
        if (memresp_val) begin
          state_next = cache_pkg::st_refill_write;
        end
      end
      cache_pkg::st_refill_write: begin
        ctrl.is_refill      = 1'b1;
        ctrl.data_wen       = 1'b1;
        ctrl.tag_wen[way_q] = 1'b1;
        state_next          = cache_pkg::st_data_read;
      end
      cache_pkg::st_data_read: begin
        ctrl.read_data_en = 1'b1;
        state_next        = cache_pkg::st_data_write;
      end
      cache_pkg::st_data_write: begin
        // Reads pass through this state without a write
        ctrl.data_wen = !is_read;
        ctrl.word_en  = !is_read;
        state_next    = cache_pkg::st_resp;
      end
      cache_pkg::st_resp: begin
        state_next = cache_pkg::st_idle;
      end
      default: begin
        state_next = cache_pkg::st_idle;
      end
    endcase
  end

  assign busy          = (state != cache_pkg::st_idle);
  assign cacheresp_val = (state == cache_pkg::st_resp);
  assign memreq_val    = (state == cache_pkg::st_evict_req) ||
                         (state == cache_pkg::st_refill_req);

  // ======================================================================
  // State registers
  // ======================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= cache_pkg::st_idle;
      way_q      <= 1'b0;
      valid_bits <= '0;
      dirty_bits <= '0;
      lru_bits   <= '0;
    end else begin
      state <= state_next;
      if (state == cache_pkg::st_tag_check) begin
        way_q <= hit ? hit_way : victim_way;
      end
      // Fresh line from memory is clean
      if (state == cache_pkg::st_refill_write) begin
        valid_bits[set_idx][way_q] <= 1'b1;
        dirty_bits[set_idx][way_q] <= 1'b0;
      end
      // Every access ends here, so LRU moves to the other way
      if (state == cache_pkg::st_data_write) begin
        lru_bits[set_idx] <= ~way_q;
        if (!is_read) begin
          dirty_bits[set_idx][way_q] <= 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/cache_pkg.sv */
/*
 * Shared types and geometry for the two-way blocking data cache.
 * Every cache module and the testbench refer to these by scoped name.
 */

package cache_pkg;

  // ======================================================================
  // Geometry
  // ======================================================================

  localparam int data_nbits     = 32;
  localparam int addr_nbits     = 32;
  localparam int line_nbits     = 128;
  localparam int opaque_nbits   = 8;
  localparam int nsets          = 8;
  localparam int nways          = 2;
  localparam int idx_nbits      = 3;
  // Byte offset within a 16-byte line
  localparam int off_nbits      = 4;
  localparam int words_per_line = line_nbits / data_nbits;
  // Whole line address is kept as the tag
  localparam int tag_nbits      = addr_nbits - off_nbits;

  // ======================================================================
  // Message types
  // ======================================================================

  typedef enum logic [2:0] {
    req_read    = 3'd0,
    req_write   = 3'd1,
    req_amo_add = 3'd2,
    req_amo_and = 3'd3,
    req_amo_or  = 3'd4
  } req_type_e;

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_e;

  // Processor request of 75 bits
  typedef struct packed {
    req_type_e                type_;
    logic [opaque_nbits-1:0]  opaque;
    logic [addr_nbits-1:0]    addr;
    logic [data_nbits-1:0]    data;
  } cache_req_t;

  // Processor response of 43 bits
  typedef struct packed {
    req_type_e                type_;
    logic [opaque_nbits-1:0]  opaque;
    logic [data_nbits-1:0]    data;
  } cache_resp_t;

  // Line-wide memory request of 161 bits
  typedef struct packed {
    mem_type_e                type_;
    logic [addr_nbits-1:0]    addr;
    logic [line_nbits-1:0]    data;
  } mem_req_t;

  typedef struct packed {
    logic [line_nbits-1:0]    data;
  } mem_resp_t;

  // Control unit to datapath
  typedef struct packed {
    logic               cachereq_en;
    logic               memresp_en;
    logic               is_refill;
    logic [nways-1:0]   tag_wen;
    logic               data_wen;
    logic               way_sel;
    logic               word_en;
    logic               read_data_en;
    logic               read_tag_en;
    mem_type_e          memreq_type;
  } ctrl_t;

  typedef enum logic [3:0] {
    st_idle, st_tag_check, st_evict_read, st_evict_req, st_refill_req,
    st_refill_wait, st_refill_write, st_data_read, st_data_write, st_resp
  } cache_state_e;

endpackage
